// File: source/ads_proto_pkg.sv
package ads_proto_pkg;

	// ========================================================================
	// Host control codes
	// ========================================================================
	// Codes 6 and 7 are left undefined and fall back to idle in the decoder
	typedef enum logic [2:0] {
		CTRL_IDLE   = 3'd0, // Nothing requested
		CTRL_SYSCMD = 3'd1, // System command in i_command
		CTRL_WREG   = 3'd2, // Write one register
		CTRL_RREG   = 3'd3, // Read one register
		CTRL_RDATAC = 3'd4, // Enter continuous read
		CTRL_SDATAC = 3'd5  // Leave continuous read
	} ctrl_code_e;

	// ========================================================================
	// ADS1292 command bytes
	// ========================================================================
	typedef enum logic [7:0] {
		CMD_RESET  = 8'h06, // Done on the RESET pin
		CMD_START  = 8'h08, // Done on the START pin
		CMD_STOP   = 8'h0A, // Done on the START pin
		CMD_RDATAC = 8'h10,
		CMD_SDATAC = 8'h11
	} ads_cmd_e;

	// Register access opcodes
	// First byte is {prefix, 5-bit register address}
	localparam logic [2:0] OP_RREG = 3'b001;
	localparam logic [2:0] OP_WREG = 3'b010;

	// Second byte holds register count minus one
	localparam logic [7:0] REG_COUNT_BYTE = 8'h00; // One register only

	// ========================================================================
	// Continuous read frame
	// ========================================================================
	// Status word then channel 1 then channel 2, 24 bits each
	localparam int FRAME_BYTES = 9;
	localparam int FRAME_W     = FRAME_BYTES * 8; // 72 bits

endpackage

// File: source/ads_ctrl_pkg.sv
package ads_ctrl_pkg;

	// One SPI byte, used on every internal byte path
	typedef logic [7:0] byte_t;

	// ========================================================================
	// Sequencer FSM
	// ========================================================================
	typedef enum logic [3:0] {
		SEQ_IDLE,      // Waiting for a host request
		SEQ_PIN,       // START, STOP or RESET on device pins
		SEQ_SEND,      // Command or register bytes on SPI
		SEQ_WAIT_DRDY, // Continuous mode, waiting for DRDY fall
		SEQ_SETTLE,    // Data settling after DRDY fall
		SEQ_FRAME,     // Reading one 9-byte frame
		SEQ_HOLD       // CS held low after last byte
	} seq_state_e;

	// ========================================================================
	// SPI shifter FSM
	// ========================================================================
	// Mode 1 only, SCLK idles low
	typedef enum logic [1:0] {
		SH_IDLE, // No byte in flight
		SH_HIGH, // SCLK high half, MOSI just changed
		SH_LOW   // SCLK low half, MISO just sampled
	} shift_state_e;

endpackage

// File: source/tx_byte_fifo.sv
`timescale 1ns/1ps

module tx_byte_fifo #(
	parameter int TX_FIFO_DEPTH = 4
) (
	input  logic                i_CLK,
	input  logic                i_RSTN,
	// Write side, from sequencer
	input  logic                i_push,
	input  ads_ctrl_pkg::byte_t i_push_byte,
	// Read side, to shifter
	output logic                o_valid,
	output ads_ctrl_pkg::byte_t o_byte,
	input  logic                i_pop,
	// One pulse per freed slot
	output logic                o_credit
);

	localparam int PTR_W = (TX_FIFO_DEPTH > 1) ? $clog2(TX_FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(TX_FIFO_DEPTH + 1);

	ads_ctrl_pkg::byte_t r_mem [TX_FIFO_DEPTH];
	logic [PTR_W-1:0]    r_wr_ptr;
	logic [PTR_W-1:0]    r_rd_ptr;
	logic [CNT_W-1:0]    r_count; // Occupancy

	// Wraps at depth, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(TX_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign o_valid = (r_count != '0);
	assign o_byte  = r_mem[r_rd_ptr]; // Head entry

	always_ff @(posedge i_CLK) begin
		if (i_push)
			r_mem[r_wr_ptr] <= i_push_byte;
	end

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count  <= '0;
			o_credit <= 1'b0;
		end else begin
			o_credit <= i_pop; // Slot freed, hand credit back
			if (i_push)
				r_wr_ptr <= next_ptr(r_wr_ptr);
			if (i_pop)
				r_rd_ptr <= next_ptr(r_rd_ptr);
			case ({i_push, i_pop})
				2'b10:   r_count <= r_count + 1'b1;
				2'b01:   r_count <= r_count - 1'b1;
				default: r_count <= r_count;
			endcase
		end
	end

endmodule

// File: source/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter #(
	parameter int CLKS_PER_HALF_BIT = 64
) (
	input  logic                i_CLK,
	input  logic                i_RSTN,
	// Byte source
	input  logic                i_valid,
	input  ads_ctrl_pkg::byte_t i_byte,
	output logic                o_pop,
	// Received byte, one per sent byte
	output logic                o_rx_valid,
	output ads_ctrl_pkg::byte_t o_rx_byte,
	// SPI pins, mode 1
	output logic                o_spi_clk,
	output logic                o_spi_mosi,
	input  logic                i_spi_miso
);

	localparam int HALF_W = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;

	ads_ctrl_pkg::shift_state_e r_state;
	logic [HALF_W-1:0]          r_half_cnt; // Cycles within half bit
	logic [2:0]                 r_bit_cnt;
	ads_ctrl_pkg::byte_t        r_tx_sr;    // Next MOSI bit at [7]
	ads_ctrl_pkg::byte_t        r_rx_sr;

	logic w_half_end;
	logic w_byte_end;

	assign w_half_end = (r_half_cnt == HALF_W'(CLKS_PER_HALF_BIT - 1));
	// Last cycle of eighth low half
	assign w_byte_end = (r_state == ads_ctrl_pkg::SH_LOW) && w_half_end && (r_bit_cnt == 3'd7);

	// Take next byte when idle or right as current byte ends
	assign o_pop      = i_valid && ((r_state == ads_ctrl_pkg::SH_IDLE) || w_byte_end);
	assign o_rx_valid = w_byte_end;
	assign o_rx_byte  = r_rx_sr;

	// ========================================================================
	// SCLK and MOSI generation
	// ========================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state    <= ads_ctrl_pkg::SH_IDLE;
			r_half_cnt <= '0;
			r_bit_cnt  <= '0;
			o_spi_clk  <= 1'b0; // CPOL 0
			o_spi_mosi <= 1'b0;
		end else if (o_pop) begin
			// First rising edge, MSB goes out
			r_state    <= ads_ctrl_pkg::SH_HIGH;
			r_half_cnt <= '0;
			r_bit_cnt  <= '0;
			o_spi_clk  <= 1'b1;
			o_spi_mosi <= i_byte[7];
		end else begin
			case (r_state)
				ads_ctrl_pkg::SH_HIGH: begin
					r_half_cnt <= w_half_end ? '0 : r_half_cnt + 1'b1;
					if (w_half_end) begin
						o_spi_clk <= 1'b0; // Falling edge, MISO sampled below
						r_state   <= ads_ctrl_pkg::SH_LOW;
					end
				end
				ads_ctrl_pkg::SH_LOW: begin
					r_half_cnt <= w_half_end ? '0 : r_half_cnt + 1'b1;
					if (w_byte_end) begin
						r_state <= ads_ctrl_pkg::SH_IDLE; // Nothing waiting
					end else if (w_half_end) begin
						r_bit_cnt  <= r_bit_cnt + 3'd1;
						o_spi_clk  <= 1'b1; // Rising edge shifts MOSI
						o_spi_mosi <= r_tx_sr[7];
						r_state    <= ads_ctrl_pkg::SH_HIGH;
					end
				end
				default: r_half_cnt <= '0;
			endcase
		end
	end

	// Shift registers
	always_ff @(posedge i_CLK) begin
		if (o_pop)
			r_tx_sr <= {i_byte[6:0], 1'b0};
		else if ((r_state == ads_ctrl_pkg::SH_LOW) && w_half_end)
			r_tx_sr <= {r_tx_sr[6:0], 1'b0};
		if ((r_state == ads_ctrl_pkg::SH_HIGH) && w_half_end)
			r_rx_sr <= {r_rx_sr[6:0], i_spi_miso}; // MSB first
	end

endmodule

// File: source/ads_sequencer.sv
`timescale 1ns/1ps

module ads_sequencer #(
	parameter int TX_FIFO_DEPTH      = 4,
	parameter int CS_HOLD_CYCLES     = 5,
	parameter int DATA_SETTLE_CYCLES = 500
) (
	input  logic                              i_CLK,
	input  logic                              i_RSTN,
	// Host side
	input  ads_proto_pkg::ctrl_code_e         i_control,
	input  ads_ctrl_pkg::byte_t               i_command,
	input  ads_ctrl_pkg::byte_t               i_reg_addr,
	input  ads_ctrl_pkg::byte_t               i_reg_data,
	output logic [ads_proto_pkg::FRAME_W-1:0] o_data_out,
	output logic                              o_frame_valid,
	output logic                              o_busy,
	// Device pins
	input  logic                              i_drdy_n,
	output logic                              o_start,
	output logic                              o_ads_reset_n,
	output logic                              o_spi_csn,
	// TX FIFO side
	output logic                              o_push,
	output ads_ctrl_pkg::byte_t               o_push_byte,
	input  logic                              i_credit,
	// Shifter side
	input  logic                              i_rx_valid,
	input  ads_ctrl_pkg::byte_t               i_rx_byte
);

	// One counter serves pin pulse, settle wait and CS hold
	localparam int CNT_MAX = (DATA_SETTLE_CYCLES > CS_HOLD_CYCLES) ?
		DATA_SETTLE_CYCLES : CS_HOLD_CYCLES;
	localparam int CNT_W   = $clog2(CNT_MAX + 1);
	localparam int CRED_W  = $clog2(TX_FIFO_DEPTH + 1);

	ads_ctrl_pkg::seq_state_e  r_state;
	ads_proto_pkg::ctrl_code_e r_req;     // Request being served
	ads_ctrl_pkg::byte_t       r_cmd;     // Single command byte to send
	logic [4:0]                r_addr;    // Register address
	ads_ctrl_pkg::byte_t       r_data;    // Register write data
	logic [CNT_W-1:0]          r_cnt;
	logic [CRED_W-1:0]         r_credits; // Free FIFO slots
	logic [3:0]                r_len;     // Bytes in this transfer
	logic [3:0]                r_tx_idx;  // Bytes pushed so far
	logic [3:0]                r_rx_cnt;  // Bytes received so far
	logic [2:0]                r_drdy_sr; // Sync plus previous sample

	logic w_drdy_fall;
	logic w_pin_cmd;
	logic w_sending;
	logic w_last_rx;

	assign w_drdy_fall = r_drdy_sr[2] & ~r_drdy_sr[1];
	assign w_pin_cmd   = (i_command == ads_proto_pkg::CMD_START) ||
		(i_command == ads_proto_pkg::CMD_STOP) ||
		(i_command == ads_proto_pkg::CMD_RESET);
	assign w_sending   = (r_state == ads_ctrl_pkg::SEQ_SEND) ||
		(r_state == ads_ctrl_pkg::SEQ_FRAME);
	assign w_last_rx   = w_sending && i_rx_valid && (r_rx_cnt == r_len - 4'd1);

	// Push only with a credit in hand
	assign o_push = w_sending && (r_tx_idx != r_len) && (r_credits != '0);

	// Byte chosen by request and position
	always_comb begin
		o_push_byte = r_cmd;
		if (r_state == ads_ctrl_pkg::SEQ_FRAME) begin
			o_push_byte = 8'h00; // Dummy byte clocks frame data out
		end else if ((r_req == ads_proto_pkg::CTRL_WREG) ||
			(r_req == ads_proto_pkg::CTRL_RREG)) begin
			case (r_tx_idx)
				4'd0: o_push_byte = {(r_req == ads_proto_pkg::CTRL_WREG) ?
					ads_proto_pkg::OP_WREG : ads_proto_pkg::OP_RREG, r_addr};
				4'd1: o_push_byte = ads_proto_pkg::REG_COUNT_BYTE;
				default: o_push_byte = (r_req == ads_proto_pkg::CTRL_WREG) ? r_data : 8'h00;
			endcase
		end
	end

	// ========================================================================
	// Control FSM
	// ========================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state       <= ads_ctrl_pkg::SEQ_IDLE;
			r_req         <= ads_proto_pkg::CTRL_IDLE;
			r_cnt         <= '0;
			r_credits     <= CRED_W'(TX_FIFO_DEPTH);
			r_len         <= '0;
			r_tx_idx      <= '0;
			r_rx_cnt      <= '0;
			r_drdy_sr     <= 3'b111; // DRDY idles high
			o_busy        <= 1'b0;
			o_frame_valid <= 1'b0;
			o_start       <= 1'b0;
			o_ads_reset_n <= 1'b1;
			o_spi_csn     <= 1'b1;
		end else begin
			r_drdy_sr     <= {r_drdy_sr[1:0], i_drdy_n};
			o_frame_valid <= 1'b0;

			case ({o_push, i_credit})
				2'b10:   r_credits <= r_credits - 1'b1;
				2'b01:   r_credits <= r_credits + 1'b1;
				default: r_credits <= r_credits; // Both or neither
			endcase
			if (o_push)
				r_tx_idx <= r_tx_idx + 4'd1;
			if (w_sending && i_rx_valid)
				r_rx_cnt <= r_rx_cnt + 4'd1;

			case (r_state)
				ads_ctrl_pkg::SEQ_IDLE: begin
					r_req    <= i_control;
					r_cnt    <= '0;
					r_tx_idx <= '0;
					r_rx_cnt <= '0;
					case (i_control)
						ads_proto_pkg::CTRL_SYSCMD: begin
							o_busy <= 1'b1;
							if (w_pin_cmd) begin
								r_state <= ads_ctrl_pkg::SEQ_PIN; // No SPI at all
								if (i_command == ads_proto_pkg::CMD_START)
									o_start <= 1'b1;
								else if (i_command == ads_proto_pkg::CMD_STOP)
									o_start <= 1'b0;
								else
									o_ads_reset_n <= 1'b0;
							end else begin
								o_spi_csn <= 1'b0;
								r_len     <= 4'd1;
								r_state   <= ads_ctrl_pkg::SEQ_SEND;
							end
						end
						ads_proto_pkg::CTRL_WREG,
						ads_proto_pkg::CTRL_RREG: begin
							o_busy    <= 1'b1;
							o_spi_csn <= 1'b0;
							r_len     <= 4'd3; // Opcode, count, data
							r_state   <= ads_ctrl_pkg::SEQ_SEND;
						end
						ads_proto_pkg::CTRL_RDATAC: begin
							o_busy    <= 1'b1;
							o_spi_csn <= 1'b0;
							o_start   <= 1'b1; // Conversions run from here on
							r_len     <= 4'd1;
							r_state   <= ads_ctrl_pkg::SEQ_SEND;
						end
						default: r_state <= ads_ctrl_pkg::SEQ_IDLE; // SDATAC ignored here
					endcase
				end
				ads_ctrl_pkg::SEQ_PIN: begin
					r_cnt <= r_cnt + 1'b1;
					if (r_cnt == CNT_W'(1)) begin // Second cycle
						o_busy        <= 1'b0;
						o_ads_reset_n <= 1'b1;
						r_state       <= ads_ctrl_pkg::SEQ_IDLE;
					end
				end
				ads_ctrl_pkg::SEQ_SEND: begin
					r_cnt <= '0;
					if (w_last_rx)
						r_state <= (r_req == ads_proto_pkg::CTRL_RDATAC) ?
							ads_ctrl_pkg::SEQ_WAIT_DRDY : ads_ctrl_pkg::SEQ_HOLD;
				end
				ads_ctrl_pkg::SEQ_WAIT_DRDY: begin
					r_cnt    <= '0;
					r_tx_idx <= '0;
					r_rx_cnt <= '0;
					if (i_control == ads_proto_pkg::CTRL_SDATAC) begin
						r_req   <= ads_proto_pkg::CTRL_SDATAC;
						o_start <= 1'b0;
						r_len   <= 4'd1;
						r_state <= ads_ctrl_pkg::SEQ_SEND;
					end else if (w_drdy_fall) begin
						r_len   <= 4'(ads_proto_pkg::FRAME_BYTES);
						r_state <= ads_ctrl_pkg::SEQ_SETTLE;
					end
				end
				ads_ctrl_pkg::SEQ_SETTLE: begin
					r_cnt <= r_cnt + 1'b1;
					if (r_cnt == CNT_W'(DATA_SETTLE_CYCLES - 1))
						r_state <= ads_ctrl_pkg::SEQ_FRAME;
				end
				ads_ctrl_pkg::SEQ_FRAME: begin
					if (w_last_rx) begin
						o_frame_valid <= 1'b1; // Same edge as last shift
						r_state       <= ads_ctrl_pkg::SEQ_WAIT_DRDY;
					end
				end
				ads_ctrl_pkg::SEQ_HOLD: begin
					// Hold state lasts CS_HOLD_CYCLES cycles
					r_cnt <= r_cnt + 1'b1;
					if (r_cnt == CNT_W'(CS_HOLD_CYCLES - 1)) begin
						o_busy    <= 1'b0;
						o_spi_csn <= 1'b1;
						r_state   <= ads_ctrl_pkg::SEQ_IDLE;
					end
				end
				default: r_state <= ads_ctrl_pkg::SEQ_IDLE;
			endcase
		end
	end

	// Request payload and received data
	always_ff @(posedge i_CLK) begin
		if (r_state == ads_ctrl_pkg::SEQ_IDLE) begin
			r_cmd  <= (i_control == ads_proto_pkg::CTRL_RDATAC) ?
				ads_proto_pkg::CMD_RDATAC : i_command;
			r_addr <= i_reg_addr[4:0];
			r_data <= i_reg_data;
		end else if (r_state == ads_ctrl_pkg::SEQ_WAIT_DRDY) begin
			r_cmd <= ads_proto_pkg::CMD_SDATAC; // Only command allowed next
		end
		if (i_rx_valid) begin
			if (r_state == ads_ctrl_pkg::SEQ_FRAME)
				o_data_out <= {o_data_out[ads_proto_pkg::FRAME_W-9:0], i_rx_byte}; // MSB first
			else if ((r_state == ads_ctrl_pkg::SEQ_SEND) &&
				(r_req == ads_proto_pkg::CTRL_RREG) && (r_rx_cnt == 4'd2))
				o_data_out[7:0] <= i_rx_byte; // Register value on third byte
		end
	end

endmodule

// File: source/ads1292_ctrl_top.sv
`timescale 1ns/1ps

module ads1292_ctrl_top #(
	parameter int CLKS_PER_HALF_BIT  = 64,  // SCLK half period in clocks
	parameter int TX_FIFO_DEPTH      = 4,
	parameter int CS_HOLD_CYCLES     = 5,   // CS low after last byte
	parameter int DATA_SETTLE_CYCLES = 500  // Wait after DRDY fall
) (
	input  logic                              i_CLK,
	input  logic                              i_RSTN,
	// Host requests
	input  ads_proto_pkg::ctrl_code_e         i_control,
	input  ads_ctrl_pkg::byte_t               i_command,
	input  ads_ctrl_pkg::byte_t               i_reg_addr,
	input  ads_ctrl_pkg::byte_t               i_reg_data,
	output logic [ads_proto_pkg::FRAME_W-1:0] o_data_out,
	output logic                              o_frame_valid,
	output logic                              o_busy,
	// SPI pins
	output logic                              o_spi_clk,
	output logic                              o_spi_mosi,
	input  logic                              i_spi_miso,
	output logic                              o_spi_csn,
	// ADS1292 control pins
	input  logic                              i_drdy_n,
	output logic                              o_start,
	output logic                              o_ads_reset_n
);

	// Sequencer to FIFO
	logic                w_push;
	ads_ctrl_pkg::byte_t w_push_byte;
	logic                w_credit;
	// FIFO to shifter
	logic                w_fifo_valid;
	ads_ctrl_pkg::byte_t w_fifo_byte;
	logic                w_pop;
	// Shifter back to sequencer
	logic                w_rx_valid;
	ads_ctrl_pkg::byte_t w_rx_byte;

	ads_sequencer #(
		.TX_FIFO_DEPTH      (TX_FIFO_DEPTH),
		.CS_HOLD_CYCLES     (CS_HOLD_CYCLES),
		.DATA_SETTLE_CYCLES (DATA_SETTLE_CYCLES)
	) u_sequencer (
		.i_CLK         (i_CLK),
		.i_RSTN        (i_RSTN),
		.i_control     (i_control),
		.i_command     (i_command),
		.i_reg_addr    (i_reg_addr),
		.i_reg_data    (i_reg_data),
		.o_data_out    (o_data_out),
		.o_frame_valid (o_frame_valid),
		.o_busy        (o_busy),
		.i_drdy_n      (i_drdy_n),
		.o_start       (o_start),
		.o_ads_reset_n (o_ads_reset_n),
		.o_spi_csn     (o_spi_csn),
		.o_push        (w_push),
		.o_push_byte   (w_push_byte),
		.i_credit      (w_credit),
		.i_rx_valid    (w_rx_valid),
		.i_rx_byte     (w_rx_byte)
	);

	tx_byte_fifo #(
		.TX_FIFO_DEPTH (TX_FIFO_DEPTH)
	) u_tx_fifo (
		.i_CLK       (i_CLK),
		.i_RSTN      (i_RSTN),
		.i_push      (w_push),
		.i_push_byte (w_push_byte),
		.o_valid     (w_fifo_valid),
		.o_byte      (w_fifo_byte),
		.i_pop       (w_pop),
		.o_credit    (w_credit)
	);

	spi_shifter #(
		.CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
	) u_shifter (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.i_valid    (w_fifo_valid),
		.i_byte     (w_fifo_byte),
		.o_pop      (w_pop),
		.o_rx_valid (w_rx_valid),
		.o_rx_byte  (w_rx_byte),
		.o_spi_clk  (o_spi_clk),
		.o_spi_mosi (o_spi_mosi),
		.i_spi_miso (i_spi_miso)
	);

endmodule

// File: testbench/ads1292_ctrl_sva.sv
`timescale 1ns/1ps

module ads1292_ctrl_sva (
	input logic i_CLK,
	input logic i_RSTN,
	input logic o_spi_clk,
	input logic o_spi_csn,
	input logic o_frame_valid,
	input logic o_busy
);

	// SCLK parked while the device is deselected
	sclk_quiet_when_deselected: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		o_spi_csn |-> $stable(o_spi_clk))
		else $error("SCLK toggled while CS was high");

	// Frame strobe is a single-cycle pulse
	frame_valid_one_cycle: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		o_frame_valid |=> !o_frame_valid)
		else $error("frame_valid stayed high for more than one cycle");

	// End of CS hold coincides with end of busy
	csn_rise_with_busy_fall: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		$rose(o_spi_csn) |-> $fell(o_busy))
		else $error("CS rose without busy falling in the same cycle");

endmodule

bind ads1292_ctrl_top ads1292_ctrl_sva u_sva (
	.i_CLK         (i_CLK),
	.i_RSTN        (i_RSTN),
	.o_spi_clk     (o_spi_clk),
	.o_spi_csn     (o_spi_csn),
	.o_frame_valid (o_frame_valid),
	.o_busy        (o_busy)
);

// File: testbench/tb_ads1292_ctrl.sv
`timescale 1ns/1ps

module tb_ads1292_ctrl;

	localparam int HALF_BIT    = 2;  // SCLK half period in clocks
	localparam int FIFO_DEPTH  = 4;
	localparam int HOLD        = 5;
	localparam int SETTLE      = 20;
	localparam int RST_CYCLES  = 16;
	localparam int TOTAL_BYTES = 18; // 1 + 3 + 3 + 1 + 9 + 1 SPI bytes over all tests
	localparam int N_REQUESTS  = 8;
	localparam int MAX_CYCLES  = TOTAL_BYTES * 32 * HALF_BIT + SETTLE +
		N_REQUESTS * (HOLD + 8) + RST_CYCLES + 200;

	logic                      i_CLK;
	logic                      i_RSTN;
	ads_proto_pkg::ctrl_code_e i_control;
	ads_ctrl_pkg::byte_t       i_command;
	ads_ctrl_pkg::byte_t       i_reg_addr;
	ads_ctrl_pkg::byte_t       i_reg_data;
	logic [71:0]               o_data_out;
	logic                      o_frame_valid;
	logic                      o_busy;
	logic                      o_spi_clk;
	logic                      o_spi_mosi;
	logic                      i_spi_miso;
	logic                      o_spi_csn;
	logic                      i_drdy_n;
	logic                      o_start;
	logic                      o_ads_reset_n;

	// Device model state
	ads_ctrl_pkg::byte_t mosi_q[$];   // Bytes seen on MOSI
	ads_ctrl_pkg::byte_t miso_q[$];   // Preloaded reply bytes
	ads_ctrl_pkg::byte_t miso_log[$]; // Reply bytes actually sent
	ads_ctrl_pkg::byte_t miso_cur;
	ads_ctrl_pkg::byte_t mosi_sr;
	int                  miso_bit;
	int                  mosi_bit;
	int                  sclk_edges;
	int                  cycle_cnt;
	int                  n_checks;
	int                  n_errors;

	ads1292_ctrl_top #(
		.CLKS_PER_HALF_BIT  (HALF_BIT),
		.TX_FIFO_DEPTH      (FIFO_DEPTH),
		.CS_HOLD_CYCLES     (HOLD),
		.DATA_SETTLE_CYCLES (SETTLE)
	) UUT (.*);

	always #10 i_CLK = ~i_CLK; // 20 ns period

	// ========================================================================
	// ADS1292 SPI model, mode 1
	// ========================================================================
	always @(posedge o_spi_clk) begin
		if (!o_spi_csn) begin
			if (miso_bit == 0) begin
				if (miso_q.size() > 0)
					miso_cur = miso_q.pop_front();
				else
					miso_cur = 8'h00; // Ran dry
				miso_log.push_back(miso_cur);
			end
			i_spi_miso <= miso_cur[7 - miso_bit]; // Shift out on rising edge
			miso_bit = (miso_bit + 1) % 8;
		end
	end

	always @(negedge o_spi_clk) begin
		if (!o_spi_csn) begin
			mosi_sr  = {mosi_sr[6:0], o_spi_mosi}; // MSB first
			mosi_bit = (mosi_bit + 1) % 8;
			if (mosi_bit == 0)
				mosi_q.push_back(mosi_sr);
		end
	end

	always @(o_spi_clk) sclk_edges++;

	// Watchdog on total run length
	always @(posedge i_CLK) begin
		cycle_cnt++;
		if (cycle_cnt > MAX_CYCLES) begin
			$display("Timeout: the DUT did not finish within %0d cycles", MAX_CYCLES);
			$display("Checks: %0d, errors: %0d", n_checks, n_errors);
			$display("Test failed");
			$finish;
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================
	task automatic check_value(input string what, input logic [71:0] got,
		input logic [71:0] exp);
		n_checks++;
		assert (got === exp) else begin
			n_errors++;
			$display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_mosi(input string what, input ads_ctrl_pkg::byte_t exp[$]);
		check_value({what, " byte count"}, mosi_q.size(), exp.size());
		for (int i = 0; i < exp.size() && i < mosi_q.size(); i++)
			check_value($sformatf("%s byte %0d", what, i), mosi_q[i], exp[i]);
	endtask

	task automatic clear_logs();
		mosi_q.delete();
		miso_log.delete();
	endtask

	// One-cycle request, sampled by the DUT on the second edge
	task automatic send_request(input ads_proto_pkg::ctrl_code_e code,
		input ads_ctrl_pkg::byte_t cmd, input ads_ctrl_pkg::byte_t addr,
		input ads_ctrl_pkg::byte_t data);
		@(posedge i_CLK);
		i_control  <= code;
		i_command  <= cmd;
		i_reg_addr <= addr;
		i_reg_data <= data;
		@(posedge i_CLK);
		i_control  <= ads_proto_pkg::CTRL_IDLE;
	endtask

	task automatic wait_idle();
		do
			@(negedge i_CLK);
		while (o_busy);
	endtask

	// Pin command, then count busy and reset-low cycles until done
	task automatic run_pin_command(input ads_ctrl_pkg::byte_t cmd, output int busy_cycles,
		output int low_cycles);
		busy_cycles = 0;
		low_cycles  = 0;
		send_request(ads_proto_pkg::CTRL_SYSCMD, cmd, 8'h00, 8'h00);
		do begin
			@(negedge i_CLK);
			if (o_busy)
				busy_cycles++;
			if (!o_ads_reset_n)
				low_cycles++;
		end while (o_busy);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================
	task automatic after_reset_state();
		@(negedge i_CLK);
		check_value("busy after reset", o_busy, 0);
		check_value("frame_valid after reset", o_frame_valid, 0);
		check_value("CS after reset", o_spi_csn, 1);
		check_value("START after reset", o_start, 0);
		check_value("RESET pin after reset", o_ads_reset_n, 1);
	endtask

	task automatic spi_system_command();
		ads_ctrl_pkg::byte_t cmd;
		ads_ctrl_pkg::byte_t exp[$];
		cmd = 8'h06;
		while (cmd == 8'h06 || cmd == 8'h08 || cmd == 8'h0A)
			cmd = 8'($urandom); // Pin commands never reach SPI
		exp.push_back(cmd);
		clear_logs();
		send_request(ads_proto_pkg::CTRL_SYSCMD, cmd, 8'h00, 8'h00);
		@(negedge i_CLK);
		check_value("CS during command", o_spi_csn, 0);
		wait_idle();
		check_value("CS after command", o_spi_csn, 1);
		check_mosi("system command", exp);
	endtask

	task automatic pin_commands();
		int busy_cycles;
		int low_cycles;
		int edges_before;
		edges_before = sclk_edges;
		run_pin_command(8'h08, busy_cycles, low_cycles); // START
		check_value("START busy cycles", busy_cycles, 2);
		check_value("START pin", o_start, 1);
		run_pin_command(8'h0A, busy_cycles, low_cycles); // STOP
		check_value("STOP busy cycles", busy_cycles, 2);
		check_value("START pin after STOP", o_start, 0);
		run_pin_command(8'h06, busy_cycles, low_cycles); // RESET
		check_value("RESET busy cycles", busy_cycles, 2);
		check_value("RESET low cycles", low_cycles, 2);
		check_value("RESET pin released", o_ads_reset_n, 1);
		check_value("SCLK edges on pin commands", sclk_edges, edges_before);
	endtask

	task automatic register_write();
		ads_ctrl_pkg::byte_t addr;
		ads_ctrl_pkg::byte_t data;
		ads_ctrl_pkg::byte_t exp[$];
		addr = 8'($urandom);
		data = 8'($urandom);
		exp.push_back(8'h40 | {3'b000, addr[4:0]}); // Opcode 010 plus address
		exp.push_back(8'h00);                       // One register
		exp.push_back(data);
		clear_logs();
		send_request(ads_proto_pkg::CTRL_WREG, 8'h00, addr, data);
		wait_idle();
		check_mosi("WREG", exp);
	endtask

	task automatic register_read();
		ads_ctrl_pkg::byte_t addr;
		ads_ctrl_pkg::byte_t exp[$];
		addr = 8'($urandom);
		exp.push_back(8'h20 | {3'b000, addr[4:0]}); // Opcode 001 plus address
		exp.push_back(8'h00);
		exp.push_back(8'h00);                       // Dummy clocks the value out
		clear_logs();
		send_request(ads_proto_pkg::CTRL_RREG, 8'h00, addr, 8'h00);
		wait_idle();
		check_mosi("RREG", exp);
		check_value("RREG reply count", miso_log.size(), 3);
		if (miso_log.size() >= 3)
			check_value("RREG data", o_data_out[7:0], miso_log[2]);
	endtask

	task automatic continuous_read();
		ads_ctrl_pkg::byte_t exp[$];
		logic [71:0]         frame;
		clear_logs();
		exp.push_back(8'h10);
		send_request(ads_proto_pkg::CTRL_RDATAC, 8'h00, 8'h00, 8'h00);
		while (mosi_q.size() == 0)
			@(negedge i_CLK);
		// Last low half of the byte, then the DUT listens for DRDY
		repeat (HALF_BIT + 4) @(negedge i_CLK);
		check_mosi("RDATAC", exp);
		check_value("START pin in RDATAC", o_start, 1);
		check_value("busy in RDATAC", o_busy, 1);

		clear_logs();
		@(posedge i_CLK);
		i_drdy_n <= 1'b0; // New sample ready
		do
			@(negedge i_CLK);
		while (!o_frame_valid);
		frame = '0;
		foreach (miso_log[i])
			frame = {frame[63:0], miso_log[i]}; // First byte ends up on top
		check_value("frame reply count", miso_log.size(), 9);
		check_value("frame data", o_data_out, frame);
		exp.delete();
		for (int i = 0; i < 9; i++)
			exp.push_back(8'h00);
		check_mosi("frame dummies", exp);
		@(posedge i_CLK);
		i_drdy_n <= 1'b1;

		clear_logs();
		exp.delete();
		exp.push_back(8'h11);
		send_request(ads_proto_pkg::CTRL_SDATAC, 8'h00, 8'h00, 8'h00);
		wait_idle();
		check_mosi("SDATAC", exp);
		check_value("START pin after SDATAC", o_start, 0);
		check_value("CS after SDATAC", o_spi_csn, 1);
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		void'($urandom(32'h440e));
		i_CLK      = 1'b0;
		i_RSTN     = 1'b0;
		i_control  = ads_proto_pkg::CTRL_IDLE;
		i_command  = 8'h00;
		i_reg_addr = 8'h00;
		i_reg_data = 8'h00;
		i_spi_miso = 1'b0;
		i_drdy_n   = 1'b1; // DRDY idles high
		for (int i = 0; i < 64; i++)
			miso_q.push_back(8'($urandom));
		repeat (RST_CYCLES) @(posedge i_CLK);
		i_RSTN <= 1'b1;
		after_reset_state();
		spi_system_command();
		pin_commands();
		register_write();
		register_read();
		continuous_read();
		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: ads1292_ctrl_top.f
source/ads_proto_pkg.sv
source/ads_ctrl_pkg.sv
source/tx_byte_fifo.sv
source/spi_shifter.sv
source/ads_sequencer.sv
source/ads1292_ctrl_top.sv
testbench/ads1292_ctrl_sva.sv
testbench/tb_ads1292_ctrl.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = tb_ads1292_ctrl
FILELIST   = ads1292_ctrl_top.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
